// ==== Makefile ====
# Verilator build and run of the packet truncator testbench

SIM = obj_dir/Vtb_trunc

.PHONY: run clean

$(SIM): vlog.f hdl/trunc_params.svh hdl/stream_pkg.sv hdl/trunc_cfg_pkg.sv \
        hdl/trunc_cfg_regs.sv hdl/pkt_trunc.sv hdl/trunc_top.sv test/tb_trunc.sv
	verilator --binary --timing --assert -Wno-fatal --top-module tb_trunc -f vlog.f

run: $(SIM)
	./$(SIM) | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then exit 1; fi
	@grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== hdl/pkt_trunc.sv ====
/*
 * Cuts each packet to the limit in cfg, captured on the packet's first beat.
 * Output is registered, one cycle of latency, and dropped beats leave gaps.
 * Input keep must be non-zero and filled from byte 0 upward.
 */

`default_nettype none

`include "trunc_params.svh"

module pkt_trunc (
   input  logic                      clk,
   input  logic                      srst,
   input  logic                      in_valid,
   input  stream_pkg::stream_beat_t  in_beat,
   input  trunc_cfg_pkg::trunc_cfg_t cfg,
   output logic                      out_valid,
   output logic                      cut_pulse,
   output stream_pkg::stream_beat_t  out_beat
);

   localparam int DATA_BYTES = `TRUNC_DATA_BYTES;

   typedef enum logic [1:0] {
      PKT_START,
      PKT_PASS,
      PKT_DROP
   } pkt_state_e;

   pkt_state_e state;

   trunc_cfg_pkg::trunc_cfg_t cfg_q;
   trunc_cfg_pkg::trunc_cfg_t cur_cfg;
   trunc_cfg_pkg::byte_len_t  byte_cnt;
   trunc_cfg_pkg::byte_len_t  cur_cnt;
   trunc_cfg_pkg::byte_len_t  remain;

   logic limit_hit;
   logic near_end;
   logic cut_beat;
   logic drop_beat;
   logic keep_cut;
   logic fwd;
   logic cut_now;

   stream_pkg::beat_keep_t   keep_mask;
   stream_pkg::beat_keep_t   cut_keep;
   stream_pkg::stream_beat_t nxt_beat;

   // number of enabled bytes in a beat
   function automatic trunc_cfg_pkg::byte_len_t keep_bytes(
      input stream_pkg::beat_keep_t keep
   );
      trunc_cfg_pkg::byte_len_t n;
      n = '0;
      for (int i = 0; i < DATA_BYTES; i++) begin
         n = n + trunc_cfg_pkg::byte_len_t'(keep[i]);
      end
      return n;
   endfunction

   // ------------------------------------------------------------------------
   // cut decision
   // ------------------------------------------------------------------------

   // first beat uses the live settings and a zero count
   assign cur_cfg = (state == PKT_START) ? cfg : cfg_q;
   assign cur_cnt = (state == PKT_START) ? '0 : byte_cnt;

   assign remain    = cur_cfg.max_len - cur_cnt;
   assign limit_hit = cur_cnt >= cur_cfg.max_len;
   assign near_end  = remain <= trunc_cfg_pkg::byte_len_t'(DATA_BYTES);

   assign cut_beat  = cur_cfg.enable && !limit_hit && near_end;
   assign drop_beat = (state == PKT_DROP) || (cur_cfg.enable && limit_hit);
   assign fwd       = in_valid && !drop_beat;

   // bytes below the remaining count survive
   always_comb begin
      for (int i = 0; i < DATA_BYTES; i++) begin
         keep_mask[i] = remain > trunc_cfg_pkg::byte_len_t'(i);
      end
   end

   assign cut_keep = in_beat.keep & keep_mask;
   assign keep_cut = cut_keep != in_beat.keep;

   // counted once per packet: forced last, shortened keep, or zero limit
   assign cut_now = in_valid && (state != PKT_DROP) &&
                    ((cur_cfg.enable && limit_hit) ||
                     (cut_beat && (!in_beat.last || keep_cut)));

   // cut beat gets the new keep, last set, and cleared bytes zeroed
   always_comb begin
      nxt_beat = in_beat;
      if (cut_beat) begin
         nxt_beat.keep = cut_keep;
         nxt_beat.last = 1'b1;
         for (int i = 0; i < DATA_BYTES; i++) begin
            if (!cut_keep[i]) begin
               nxt_beat.data[8*i +: 8] = 8'h00;
            end
         end
      end
   end

   // ------------------------------------------------------------------------
   // packet FSM and output register
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (srst) begin
         state     <= PKT_START;
         out_valid <= 1'b0;
         cut_pulse <= 1'b0;
      end else begin
         out_valid <= fwd;
         cut_pulse <= cut_now;
         if (in_valid) begin
            case (state)
               PKT_START, PKT_PASS: begin
                  if (in_beat.last) begin
                     state <= PKT_START;
                  end else if (drop_beat || cut_beat) begin
                     state <= PKT_DROP;
                  end else begin
                     state <= PKT_PASS;
                  end
               end
               default: begin
                  // tail of a cut packet
                  if (in_beat.last) begin
                     state <= PKT_START;
                  end
               end
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid && (state == PKT_START)) begin
         cfg_q <= cfg;
      end
      if (fwd) begin
         byte_cnt <= cur_cnt + keep_bytes(in_beat.keep);
         out_beat <= nxt_beat;
      end
   end

   // ------------------------------------------------------------------------
   // checks
   // ------------------------------------------------------------------------
   a_keep_nonzero: assert property (
      @(posedge clk) disable iff (srst) out_valid |-> (out_beat.keep != '0)
   );

   a_quiet_after_reset: assert property (
      @(posedge clk) srst |=> !out_valid
   );

endmodule

`default_nettype wire

// ==== hdl/stream_pkg.sv ====
/*
 * Types for the beat stream.
 * Byte i of the data sits in bits 8*i+7 down to 8*i, enabled by keep bit i.
 * No back-pressure exists, so a beat is a struct with no ready field.
 */

`default_nettype none

`include "trunc_params.svh"

package stream_pkg;

   // ------------------------------------------------------------------------
   // beat fields
   // ------------------------------------------------------------------------
   typedef logic [`TRUNC_DATA_BYTES*8-1:0] beat_data_t;
   typedef logic [`TRUNC_DATA_BYTES-1:0]   beat_keep_t;

   // destination tag, carried through untouched
   typedef logic [3:0] dest_t;

   typedef struct packed {
      beat_data_t data;
      beat_keep_t keep;
      logic       last;
      dest_t      dest;
   } stream_beat_t;

endpackage

`default_nettype wire

// ==== hdl/trunc_cfg_pkg.sv ====
/*
 * Types for the configuration side of the truncator.
 * Register data is 16 bits wide; the counter register is read-only.
 */

`default_nettype none

`include "trunc_params.svh"

package trunc_cfg_pkg;

   typedef logic [`TRUNC_LEN_BITS-1:0] byte_len_t;
   typedef logic [15:0]                cfg_data_t;

   // register map, a write to the counter clears it
   typedef enum logic [1:0] {
      CFG_CTRL      = 2'd0,
      CFG_MAX_LEN   = 2'd1,
      CFG_TRUNC_CNT = 2'd2
   } cfg_addr_e;

   // live settings handed to the truncation block
   typedef struct packed {
      logic      enable;
      byte_len_t max_len;
   } trunc_cfg_t;

endpackage

`default_nettype wire

// ==== hdl/trunc_cfg_regs.sv ====
/*
 * Control registers for the truncator: enable, length limit and a
 * saturating count of cut packets. Reads return data one cycle after
 * cfg_rd. Reads and writes must not be issued in the same cycle.
 */

`default_nettype none

`include "trunc_params.svh"

module trunc_cfg_regs (
   input  logic                     clk,
   input  logic                     srst,
   input  logic                     cfg_wr,
   input  logic                     cfg_rd,
   input  trunc_cfg_pkg::cfg_addr_e cfg_addr,
   input  trunc_cfg_pkg::cfg_data_t cfg_wdata,
   input  logic                     cut_pulse,
   output logic                     cfg_rvalid,
   output trunc_cfg_pkg::cfg_data_t cfg_rdata,
   output trunc_cfg_pkg::trunc_cfg_t cfg
);

   trunc_cfg_pkg::trunc_cfg_t cfg_q;
   logic [`TRUNC_CNT_BITS-1:0] trunc_cnt;
   logic                       cnt_clr;

   // ------------------------------------------------------------------------
   // write side
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (srst) begin
         cfg_q.enable  <= 1'b0;
         cfg_q.max_len <= trunc_cfg_pkg::byte_len_t'(`TRUNC_RESET_LEN);
      end else if (cfg_wr) begin
         case (cfg_addr)
            trunc_cfg_pkg::CFG_CTRL: begin
               cfg_q.enable <= cfg_wdata[0];
            end
            trunc_cfg_pkg::CFG_MAX_LEN: begin
               cfg_q.max_len <= trunc_cfg_pkg::byte_len_t'(cfg_wdata);
            end
            default: begin
               // counter clear handled below
            end
         endcase
      end
   end

   assign cfg = cfg_q;

   // ------------------------------------------------------------------------
   // cut counter
   // ------------------------------------------------------------------------
   assign cnt_clr = cfg_wr && (cfg_addr == trunc_cfg_pkg::CFG_TRUNC_CNT);

   always_ff @(posedge clk) begin
      if (srst) begin
         trunc_cnt <= '0;
      end else if (cnt_clr) begin
         // a cut landing on the clear cycle is still counted
         trunc_cnt <= cut_pulse ? `TRUNC_CNT_BITS'(1) : '0;
      end else if (cut_pulse && (trunc_cnt != '1)) begin
         trunc_cnt <= trunc_cnt + 1'b1;
      end
   end

   // ------------------------------------------------------------------------
   // read side
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (srst) begin
         cfg_rvalid <= 1'b0;
      end else begin
         cfg_rvalid <= cfg_rd;
      end
   end

   always_ff @(posedge clk) begin
      if (cfg_rd) begin
         case (cfg_addr)
            trunc_cfg_pkg::CFG_CTRL: begin
               cfg_rdata <= trunc_cfg_pkg::cfg_data_t'(cfg_q.enable);
            end
            trunc_cfg_pkg::CFG_MAX_LEN: begin
               cfg_rdata <= trunc_cfg_pkg::cfg_data_t'(cfg_q.max_len);
            end
            trunc_cfg_pkg::CFG_TRUNC_CNT: begin
               cfg_rdata <= trunc_cfg_pkg::cfg_data_t'(trunc_cnt);
            end
            default: begin
               // unmapped address reads as zero
               cfg_rdata <= '0;
            end
         endcase
      end
   end

   // host side must serialize its accesses
   a_no_rd_wr_overlap: assert property (
      @(posedge clk) disable iff (srst) !(cfg_rd && cfg_wr)
   );

endmodule

`default_nettype wire

// ==== hdl/trunc_params.svh ====
/*
 * Sizing constants for the packet truncation subsystem.
 * Beat width is fixed at build time; the keep field is assumed contiguous.
 * The reset length applies until software writes the length register.
 */

`ifndef TRUNC_PARAMS_SVH
`define TRUNC_PARAMS_SVH

// bytes carried by one stream beat
`define TRUNC_DATA_BYTES 8

// width of any byte length or byte count
`define TRUNC_LEN_BITS 16

// truncated-packet counter width, saturates at all ones
`define TRUNC_CNT_BITS 16

// length limit loaded by reset
`define TRUNC_RESET_LEN 64

`endif

// ==== hdl/trunc_top.sv ====
/*
 * Packet truncator with its register block.
 * One cycle from input beat to output beat; the receiver takes every beat.
 * New settings apply from the next packet that starts after the write.
 */

`default_nettype none

module trunc_top (
   input  logic                     clk,
   input  logic                     srst,
   input  logic                     in_valid,
   input  stream_pkg::stream_beat_t in_beat,
   output logic                     out_valid,
   output stream_pkg::stream_beat_t out_beat,
   input  logic                     cfg_wr,
   input  logic                     cfg_rd,
   input  trunc_cfg_pkg::cfg_addr_e cfg_addr,
   input  trunc_cfg_pkg::cfg_data_t cfg_wdata,
   output logic                     cfg_rvalid,
   output trunc_cfg_pkg::cfg_data_t cfg_rdata
);

   trunc_cfg_pkg::trunc_cfg_t cfg;
   logic                      cut_pulse;

   // ------------------------------------------------------------------------
   // register block
   // ------------------------------------------------------------------------
   trunc_cfg_regs u_regs (
      .clk        (clk),
      .srst       (srst),
      .cfg_wr     (cfg_wr),
      .cfg_rd     (cfg_rd),
      .cfg_addr   (cfg_addr),
      .cfg_wdata  (cfg_wdata),
      .cut_pulse  (cut_pulse),
      .cfg_rvalid (cfg_rvalid),
      .cfg_rdata  (cfg_rdata),
      .cfg        (cfg)
   );

   // ------------------------------------------------------------------------
   // truncation datapath
   // ------------------------------------------------------------------------
   pkt_trunc u_trunc (
      .clk       (clk),
      .srst      (srst),
      .in_valid  (in_valid),
      .in_beat   (in_beat),
      .cfg       (cfg),
      .out_valid (out_valid),
      .cut_pulse (cut_pulse),
      .out_beat  (out_beat)
   );

endmodule

`default_nettype wire

// ==== test/tb_trunc.sv ====
/*
 * Testbench for trunc_top. Random packets run against a reference model
 * of the cut rule; register writes are issued only between packets.
 * Packet keep always fills from byte 0 upward, as the DUT requires.
 */

`default_nettype none

`include "trunc_params.svh"

module tb_trunc;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD = 4;
   localparam int BEAT_BYTES = `TRUNC_DATA_BYTES;
   // 64 packets of at most 6 beats and 3 idle cycles, plus register traffic
   localparam int WATCHDOG_NS = (64 * 9 + 1000) * CLK_PERIOD;

   logic                     clk;
   logic                     srst;
   logic                     in_valid;
   stream_pkg::stream_beat_t in_beat;
   logic                     out_valid;
   stream_pkg::stream_beat_t out_beat;
   logic                     cfg_wr;
   logic                     cfg_rd;
   trunc_cfg_pkg::cfg_addr_e cfg_addr;
   trunc_cfg_pkg::cfg_data_t cfg_wdata;
   logic                     cfg_rvalid;
   trunc_cfg_pkg::cfg_data_t cfg_rdata;

   // reference model state
   stream_pkg::stream_beat_t exp_q[$];
   stream_pkg::stream_beat_t exp_beat;
   time                      due_q[$];
   time                      exp_due;
   logic                     model_en;
   int unsigned              model_len;
   int unsigned              exp_cnt;
   logic [31:0]              rng_state;

   string cur_test;
   int    errors;
   int    checks;
   int    test_errors0;
   int    test_checks0;

   trunc_top UUT (.*);

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   function automatic int unsigned rand_range(input int unsigned lo, input int unsigned hi);
      return lo + (next_rand() % (hi - lo + 1));
   endfunction

   // ------------------------------------------------------------------------
   // reference model of the cut rule
   // ------------------------------------------------------------------------
   function automatic void trunc_ref(
      input stream_pkg::stream_beat_t pkt[$],
      input logic                     en,
      input int unsigned              limit
   );
      stream_pkg::stream_beat_t b;
      int unsigned sent;
      int unsigned n_in;
      int unsigned n_out;
      bit          cut;
      bit          done;
      sent = 0;
      cut  = 1'b0;
      done = 1'b0;
      for (int k = 0; k < pkt.size(); k++) begin
         b    = pkt[k];
         n_in = $countones(b.keep);
         if (done) begin
            // tail of a cut packet
         end else if (!en) begin
            exp_q.push_back(b);
         end else if (sent >= limit) begin
            // only a zero limit gets here
            cut  = 1'b1;
            done = 1'b1;
         end else if (limit - sent <= BEAT_BYTES) begin
            n_out = (n_in < limit - sent) ? n_in : limit - sent;
            if (!b.last || (n_out != n_in)) begin
               cut = 1'b1;
            end
            for (int i = 0; i < BEAT_BYTES; i++) begin
               if (i >= n_out) begin
                  b.keep[i]        = 1'b0;
                  b.data[8*i +: 8] = 8'h00;
               end
            end
            b.last = 1'b1;
            exp_q.push_back(b);
            done = 1'b1;
         end else begin
            exp_q.push_back(b);
            sent = sent + n_in;
         end
      end
      if (cut) begin
         exp_cnt++;
      end
   endfunction

   // ------------------------------------------------------------------------
   // stimulus tasks
   // ------------------------------------------------------------------------
   task automatic send_packet(input int unsigned len, input int unsigned gap);
      stream_pkg::stream_beat_t pkt[$];
      stream_pkg::stream_beat_t b;
      int unsigned nbeats;
      int unsigned tail;
      int unsigned n_fwd;
      logic [31:0] w0;
      logic [31:0] w1;
      nbeats = (len + BEAT_BYTES - 1) / BEAT_BYTES;
      tail   = len - (nbeats - 1) * BEAT_BYTES;
      b.dest = stream_pkg::dest_t'(rand_range(0, 15));
      for (int unsigned k = 0; k < nbeats; k++) begin
         w0     = next_rand();
         w1     = next_rand();
         b.data = {w1, w0};
         b.last = (k == nbeats - 1);
         b.keep = b.last ? stream_pkg::beat_keep_t'(8'hFF >> (BEAT_BYTES - tail)) : '1;
         pkt.push_back(b);
      end
      n_fwd = exp_q.size();
      trunc_ref(pkt, model_en, model_len);
      n_fwd = exp_q.size() - n_fwd;
      foreach (pkt[k]) begin
         @(posedge clk);
         in_valid <= 1'b1;
         in_beat  <= pkt[k];
         // forwarded beats are the head of the packet, seen two edges later
         if (k < n_fwd) begin
            due_q.push_back($time + 2 * CLK_PERIOD);
         end
      end
      repeat (gap) begin
         @(posedge clk);
         in_valid <= 1'b0;
      end
   endtask

   task automatic send_random(input int n, input int unsigned lo, input int unsigned hi,
                              input int unsigned max_gap);
      int unsigned len;
      int unsigned gap;
      for (int i = 0; i < n; i++) begin
         len = rand_range(lo, hi);
         gap = rand_range(0, max_gap);
         send_packet(len, gap);
      end
   endtask

   task automatic write_reg(input trunc_cfg_pkg::cfg_addr_e addr, input int unsigned value);
      @(posedge clk);
      in_valid  <= 1'b0;
      cfg_wr    <= 1'b1;
      cfg_addr  <= addr;
      cfg_wdata <= trunc_cfg_pkg::cfg_data_t'(value);
      @(posedge clk);
      cfg_wr <= 1'b0;
      case (addr)
         trunc_cfg_pkg::CFG_CTRL:    model_en = value[0];
         trunc_cfg_pkg::CFG_MAX_LEN: model_len = value & 32'hFFFF;
         default:                    exp_cnt = 0;
      endcase
   endtask

   // read data is due exactly one cycle after cfg_rd
   task automatic check_reg(input trunc_cfg_pkg::cfg_addr_e addr, input int unsigned expected);
      @(posedge clk);
      in_valid <= 1'b0;
      cfg_rd   <= 1'b1;
      cfg_addr <= addr;
      @(posedge clk);
      cfg_rd <= 1'b0;
      @(posedge clk);
      checks++;
      if (!cfg_rvalid) begin
         $display("error in %s: no read response for %s", cur_test, addr.name());
         errors++;
      end else if (cfg_rdata !== trunc_cfg_pkg::cfg_data_t'(expected)) begin
         $display("mismatch in %s: %s expected %0d, actual %0d",
                  cur_test, addr.name(), expected, cfg_rdata);
         errors++;
      end
      @(posedge clk);
      if (cfg_rvalid) begin
         $display("error in %s: read response for %s lasted more than one cycle",
                  cur_test, addr.name());
         errors++;
      end
   endtask

   task automatic start_test(input string name);
      cur_test     = name;
      test_errors0 = errors;
      test_checks0 = checks;
   endtask

   // latency is one cycle, the counter follows one cycle later
   task automatic drain();
      @(posedge clk);
      in_valid <= 1'b0;
      repeat (4) @(posedge clk);
      if (exp_q.size() != 0) begin
         $display("error in %s: %0d expected beats never came out", cur_test, exp_q.size());
         errors++;
         exp_q.delete();
         due_q.delete();
      end
   endtask

   task automatic end_test();
      $display("%s finished: %0d checks, %0d errors",
               cur_test, checks - test_checks0, errors - test_errors0);
   endtask

   // ------------------------------------------------------------------------
   // output compare
   // ------------------------------------------------------------------------
   always @(posedge clk) begin
      if (out_valid) begin
         if ((exp_q.size() == 0) || (due_q.size() == 0)) begin
            $display("error in %s: output beat arrived with none expected", cur_test);
            errors++;
         end else begin
            exp_beat = exp_q.pop_front();
            exp_due  = due_q.pop_front();
            checks++;
            if (out_beat !== exp_beat) begin
               $display("mismatch in %s: expected %h, actual %h", cur_test, exp_beat, out_beat);
               errors++;
            end
            if ($time != exp_due) begin
               $display("mismatch in %s: beat expected at %0d ns, actual %0d ns",
                        cur_test, exp_due, $time);
               errors++;
            end
         end
      end
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog: run still going after %0d ns", WATCHDOG_NS);
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      int unsigned lim;
      rng_state = 32'd10;
      errors    = 0;
      checks    = 0;
      exp_cnt   = 0;
      model_en  = 1'b0;
      model_len = `TRUNC_RESET_LEN;
      cur_test  = "reset";
      srst      = 1'b1;
      in_valid  = 1'b0;
      in_beat   = '0;
      cfg_wr    = 1'b0;
      cfg_rd    = 1'b0;
      cfg_addr  = trunc_cfg_pkg::CFG_CTRL;
      cfg_wdata = '0;
      repeat (3) @(posedge clk);
      srst <= 1'b0;

      start_test("pass_through");
      send_random(12, 1, 40, 3);
      drain();
      end_test();

      start_test("cut_16_13");
      write_reg(trunc_cfg_pkg::CFG_CTRL, 1);
      write_reg(trunc_cfg_pkg::CFG_MAX_LEN, 16);
      send_random(8, 17, 40, 3);
      write_reg(trunc_cfg_pkg::CFG_MAX_LEN, 13);
      send_random(8, 14, 40, 3);
      drain();
      end_test();

      start_test("short_packets");
      write_reg(trunc_cfg_pkg::CFG_MAX_LEN, 24);
      check_reg(trunc_cfg_pkg::CFG_TRUNC_CNT, exp_cnt);
      send_random(10, 1, 24, 3);
      drain();
      check_reg(trunc_cfg_pkg::CFG_TRUNC_CNT, exp_cnt);
      end_test();

      start_test("zero_limit");
      write_reg(trunc_cfg_pkg::CFG_MAX_LEN, 0);
      send_random(6, 1, 40, 3);
      drain();
      check_reg(trunc_cfg_pkg::CFG_TRUNC_CNT, exp_cnt);
      end_test();

      start_test("readback");
      check_reg(trunc_cfg_pkg::CFG_CTRL, 1);
      check_reg(trunc_cfg_pkg::CFG_MAX_LEN, 0);
      check_reg(trunc_cfg_pkg::CFG_TRUNC_CNT, exp_cnt);
      write_reg(trunc_cfg_pkg::CFG_MAX_LEN, 16'h1234);
      check_reg(trunc_cfg_pkg::CFG_MAX_LEN, 16'h1234);
      write_reg(trunc_cfg_pkg::CFG_CTRL, 0);
      check_reg(trunc_cfg_pkg::CFG_CTRL, 0);
      write_reg(trunc_cfg_pkg::CFG_CTRL, 1);
      write_reg(trunc_cfg_pkg::CFG_TRUNC_CNT, 0);
      check_reg(trunc_cfg_pkg::CFG_TRUNC_CNT, 0);
      end_test();

      // bursts with no idle cycles, new limit between bursts
      start_test("back_to_back");
      for (int burst = 0; burst < 4; burst++) begin
         lim = rand_range(1, 48);
         write_reg(trunc_cfg_pkg::CFG_MAX_LEN, lim);
         send_random(5, 1, 48, 0);
      end
      drain();
      check_reg(trunc_cfg_pkg::CFG_TRUNC_CNT, exp_cnt);
      end_test();

      $display("summary: 6 tests, %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hdl
hdl/stream_pkg.sv
hdl/trunc_cfg_pkg.sv
hdl/trunc_cfg_regs.sv
hdl/pkt_trunc.sv
hdl/trunc_top.sv
test/tb_trunc.sv
